// File: include/vga_consts.svh
`ifndef VGA_CONSTS_SVH
`define VGA_CONSTS_SVH

//////////////////////////////
// Horizontal timing
//////////////////////////////

// Phase lengths in pixel clocks, 640x480 at 60 Hz
`define H_ACTIVE_LEN 640
`define H_FRONT_LEN  16
`define H_PULSE_LEN  96
`define H_BACK_LEN   48

//////////////////////////////
// Vertical timing
//////////////////////////////

// Phase lengths in whole lines
`define V_ACTIVE_LEN 480
`define V_FRONT_LEN  10
`define V_PULSE_LEN  2
`define V_BACK_LEN   33

// Scan coordinate width, enough for 1023
`define COORD_W 10

// Packed renderer colour, 3-4-3
`define RED_W   3
`define GREEN_W 4
`define BLUE_W  3

// Per-channel width at the DAC
`define CHAN_W 8

`endif

// File: logic/vga_pkg.sv
`include "vga_consts.svh"

package vga_pkg;

	// Phases of one scan axis, in scan order
	typedef enum logic [1:0] {
		ACTIVE = 2'd0,
		FRONT  = 2'd1,
		PULSE  = 2'd2,
		BACK   = 2'd3
	} phase_t;

	// Pixel or line coordinate
	typedef logic [`COORD_W-1:0] coord_t;

	// State of one axis as seen by the other blocks
	// next is zero outside the active phase
	typedef struct packed {
		phase_t phase;
		coord_t next;
	} scan_t;

	// Colour word from the renderer
	typedef struct packed {
		logic [`RED_W-1:0]   r;
		logic [`GREEN_W-1:0] g;
		logic [`BLUE_W-1:0]  b;
	} packed_color_t;

	// Full-width colour at the output
	typedef struct packed {
		logic [`CHAN_W-1:0] red;
		logic [`CHAN_W-1:0] green;
		logic [`CHAN_W-1:0] blue;
	} rgb_t;

	// Everything that leaves for the monitor
	// Sync and blank are active low
	typedef struct packed {
		rgb_t color;
		logic hsync;
		logic vsync;
		logic blank;
	} vga_out_t;

endpackage

// File: logic/line_timing.sv
`timescale 1ns/100ps
`include "vga_consts.svh"

module line_timing #(
	parameter int ACTIVE = `H_ACTIVE_LEN,
	parameter int FRONT  = `H_FRONT_LEN,
	parameter int PULSE  = `H_PULSE_LEN,
	parameter int BACK   = `H_BACK_LEN
) (
	input  logic           M10k_pll,
	input  logic           reset,
	output vga_pkg::scan_t h_scan,
	output logic           line_end
);
	import vga_pkg::*;

	// Current phase and clock count inside it
	phase_t phase;
	coord_t count;

	// Decoded from the current phase
	coord_t phase_last;
	phase_t phase_next;
	logic   phase_done;

	//////////////////////////////
	// Phase decode
	//////////////////////////////

	// Phase parameters shadow the enum names, so use scoped literals
	always_comb begin
		phase_last = coord_t'(ACTIVE - 1);
		phase_next = vga_pkg::FRONT;
		case (phase)
			vga_pkg::FRONT: begin
				phase_last = coord_t'(FRONT - 1);
				phase_next = vga_pkg::PULSE;
			end
			vga_pkg::PULSE: begin
				phase_last = coord_t'(PULSE - 1);
				phase_next = vga_pkg::BACK;
			end
			vga_pkg::BACK: begin
				phase_last = coord_t'(BACK - 1);
				phase_next = vga_pkg::ACTIVE;
			end
			default: begin
				phase_last = coord_t'(ACTIVE - 1);
				phase_next = vga_pkg::FRONT;
			end
		endcase
	end

	// Last pixel clock of this phase
	assign phase_done = (count == phase_last);

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			phase    <= vga_pkg::ACTIVE;
			count    <= '0;
			line_end <= 1'b0;
		end else begin
			// Counter restarts on every phase change
			if (phase_done) begin
				phase <= phase_next;
				count <= '0;
			end else begin
				count <= count + coord_t'(1);
			end
			// One clock early, so the pulse lands on the last back porch clock
			line_end <= (phase == vga_pkg::BACK) && (count == coord_t'(BACK - 2));
		end
	end

	// Published pixel, zero outside the active span
	assign h_scan.phase = phase;
	assign h_scan.next  = (phase == vga_pkg::ACTIVE) ? count : '0;

endmodule

// File: logic/frame_timing.sv
`timescale 1ns/100ps
`include "vga_consts.svh"

module frame_timing #(
	parameter int ACTIVE = `V_ACTIVE_LEN,
	parameter int FRONT  = `V_FRONT_LEN,
	parameter int PULSE  = `V_PULSE_LEN,
	parameter int BACK   = `V_BACK_LEN
) (
	input  logic           M10k_pll,
	input  logic           reset,
	input  logic           line_end,
	output vga_pkg::scan_t v_scan
);
	import vga_pkg::*;

	// Current phase and line count inside it
	phase_t phase;
	coord_t count;

	// Decoded from the current phase
	coord_t phase_last;
	phase_t phase_next;
	logic   phase_done;

	//////////////////////////////
	// Phase decode
	//////////////////////////////

	// Same four-phase order as a line, lengths in lines
	always_comb begin
		phase_last = coord_t'(ACTIVE - 1);
		phase_next = vga_pkg::FRONT;
		case (phase)
			vga_pkg::FRONT: begin
				phase_last = coord_t'(FRONT - 1);
				phase_next = vga_pkg::PULSE;
			end
			vga_pkg::PULSE: begin
				phase_last = coord_t'(PULSE - 1);
				phase_next = vga_pkg::BACK;
			end
			vga_pkg::BACK: begin
				phase_last = coord_t'(BACK - 1);
				phase_next = vga_pkg::ACTIVE;
			end
			default: begin
				phase_last = coord_t'(ACTIVE - 1);
				phase_next = vga_pkg::FRONT;
			end
		endcase
	end

	// Only a finished line can close a phase
	assign phase_done = line_end && (count == phase_last);

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	// Steps on the same edge that returns the line to active
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			phase <= vga_pkg::ACTIVE;
			count <= '0;
		end else if (phase_done) begin
			phase <= phase_next;
			count <= '0;
		end else if (line_end) begin
			count <= count + coord_t'(1);
		end
	end

	// Published line, zero during vertical blanking
	assign v_scan.phase = phase;
	assign v_scan.next  = (phase == vga_pkg::ACTIVE) ? count : '0;

endmodule

// File: logic/video_output.sv
`timescale 1ns/100ps
`include "vga_consts.svh"

module video_output (
	input  logic                   M10k_pll,
	input  logic                   reset,
	input  vga_pkg::packed_color_t color,
	input  vga_pkg::scan_t         h_scan,
	input  vga_pkg::scan_t         v_scan,
	output vga_pkg::vga_out_t      video
);
	import vga_pkg::*;

	// Renderer colour widened to the DAC channels
	rgb_t expanded;
	// Both axes inside the picture
	logic visible;
	// Sync levels for the coming cycle, low in the pulse phases
	logic hsync_next;
	logic vsync_next;

	//////////////////////////////
	// Colour expansion
	//////////////////////////////

	// Field goes to the top bits, zero fill below
	always_comb begin
		expanded.red   = {color.r, {(`CHAN_W - `RED_W){1'b0}}};
		expanded.green = {color.g, {(`CHAN_W - `GREEN_W){1'b0}}};
		expanded.blue  = {color.b, {(`CHAN_W - `BLUE_W){1'b0}}};
	end

	assign visible    = (h_scan.phase == ACTIVE) && (v_scan.phase == ACTIVE);
	assign hsync_next = (h_scan.phase != PULSE);
	assign vsync_next = (v_scan.phase != PULSE);

	//////////////////////////////
	// Output register
	//////////////////////////////

	// One clock from colour in to pixel out
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			video.color <= '0;
			video.hsync <= 1'b1;
			video.vsync <= 1'b1;
			video.blank <= 1'b1;
		end else begin
			// Black in the porches and sync pulses
			video.color <= visible ? expanded : '0;
			video.hsync <= hsync_next;
			video.vsync <= vsync_next;
			// Blank low whenever either sync is low
			video.blank <= hsync_next & vsync_next;
		end
	end

endmodule

// File: logic/vga_raster_top.sv
`timescale 1ns/100ps
`include "vga_consts.svh"

module vga_raster_top #(
	parameter int H_ACTIVE = `H_ACTIVE_LEN,
	parameter int H_FRONT  = `H_FRONT_LEN,
	parameter int H_PULSE  = `H_PULSE_LEN,
	parameter int H_BACK   = `H_BACK_LEN,
	parameter int V_ACTIVE = `V_ACTIVE_LEN,
	parameter int V_FRONT  = `V_FRONT_LEN,
	parameter int V_PULSE  = `V_PULSE_LEN,
	parameter int V_BACK   = `V_BACK_LEN
) (
	input  logic                   M10k_pll,
	input  logic                   reset,
	input  vga_pkg::packed_color_t color,
	output vga_pkg::coord_t        next_x,
	output vga_pkg::coord_t        next_y,
	output vga_pkg::vga_out_t      video
);
	import vga_pkg::*;

	// Axis state from the two sequencers
	scan_t h_scan;
	scan_t v_scan;
	// Last clock of each line
	logic  line_end;

	// Pixel clock sequencer
	line_timing #(
		.ACTIVE(H_ACTIVE),
		.FRONT (H_FRONT),
		.PULSE (H_PULSE),
		.BACK  (H_BACK)
	) line_timing_inst (
		.M10k_pll(M10k_pll),
		.reset   (reset),
		.h_scan  (h_scan),
		.line_end(line_end)
	);

	// Line sequencer
	frame_timing #(
		.ACTIVE(V_ACTIVE),
		.FRONT (V_FRONT),
		.PULSE (V_PULSE),
		.BACK  (V_BACK)
	) frame_timing_inst (
		.M10k_pll(M10k_pll),
		.reset   (reset),
		.line_end(line_end),
		.v_scan  (v_scan)
	);

	// Colour and sync register stage
	video_output video_output_inst (
		.M10k_pll(M10k_pll),
		.reset   (reset),
		.color   (color),
		.h_scan  (h_scan),
		.v_scan  (v_scan),
		.video   (video)
	);

	// Pixel the renderer must colour this cycle
	assign next_x = h_scan.next;
	assign next_y = v_scan.next;

endmodule

// File: testbench/vga_raster_checker.sv
`timescale 1ns/100ps

module vga_raster_checker #(
	parameter int H_ACTIVE  = 8,
	parameter int H_FRONT   = 2,
	parameter int H_PULSE   = 3,
	parameter int H_BACK    = 2,
	parameter int V_ACTIVE  = 4,
	parameter int V_FRONT   = 1,
	parameter int V_PULSE   = 1,
	parameter int V_BACK    = 1,
	parameter int MAX_TESTS = 64
) (
	input  logic                   M10k_pll,
	input  logic                   reset,
	input  vga_pkg::packed_color_t color,
	input  vga_pkg::coord_t        next_x,
	input  vga_pkg::coord_t        next_y,
	input  vga_pkg::vga_out_t      video,
	input  vga_pkg::packed_color_t color_tab [MAX_TESTS],
	input  vga_pkg::rgb_t          expect_tab [MAX_TESTS],
	input  int                     num_tests,
	output int                     error_count
);
	import vga_pkg::*;

	// Phase order 0 active, 1 front, 2 pulse, 3 back
	localparam int H_LEN[4] = '{H_ACTIVE, H_FRONT, H_PULSE, H_BACK};
	localparam int V_LEN[4] = '{V_ACTIVE, V_FRONT, V_PULSE, V_BACK};
	localparam int LINE_CLKS  = H_ACTIVE + H_FRONT + H_PULSE + H_BACK;
	localparam int FRAME_CLKS = LINE_CLKS * (V_ACTIVE + V_FRONT + V_PULSE + V_BACK);

	// Reference raster position during the current cycle
	int   hp, hc, vp, vc;
	logic line_done;
	// Output values the DUT must show in the current cycle
	logic exp_hsync, exp_vsync;
	rgb_t exp_color;
	// Clocks since the last sync falling edge
	int   hs_gap, vs_gap;
	logic prev_hsync, prev_vsync;

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAIL at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	// Expansion listed next to this colour in the tests file
	task automatic look_up_expansion(input packed_color_t c, output rgb_t e);
		int  i;
		logic found;
		e = '0;
		found = 1'b0;
		for (i = 0; i < num_tests; i++) begin
			if (color_tab[i] == c) begin
				e = expect_tab[i];
				found = 1'b1;
			end
		end
		if (!found) begin
			$display("Colour %0h at %0t ns has no entry in the tests file", c, $time);
			error_count++;
		end
	endtask

	//////////////////////////////
	// Compare, then step the model
	//////////////////////////////

	always @(posedge M10k_pll) begin
		if (reset) begin
			hp = 0;
			hc = 0;
			vp = 0;
			vc = 0;
			// Idle levels straight out of reset
			exp_hsync = 1'b1;
			exp_vsync = 1'b1;
			exp_color = '0;
			hs_gap = 0;
			vs_gap = 0;
			prev_hsync = 1'b1;
			prev_vsync = 1'b1;
		end else begin
			compare_value("next_x", (hp == 0) ? hc : 0, 32'(next_x));
			compare_value("next_y", (vp == 0) ? vc : 0, 32'(next_y));
			compare_value("video.hsync", 32'(exp_hsync), 32'(video.hsync));
			compare_value("video.vsync", 32'(exp_vsync), 32'(video.vsync));
			compare_value("video.blank", 32'(exp_hsync & exp_vsync), 32'(video.blank));
			compare_value("video.color", 32'(exp_color), 32'(video.color));

			// Sync edges must keep coming
			if (prev_hsync && !video.hsync) hs_gap = 0;
			else hs_gap++;
			if (prev_vsync && !video.vsync) vs_gap = 0;
			else vs_gap++;
			if (hs_gap > LINE_CLKS) begin
				$display("No hsync falling edge in %0d clocks, at %0t ns", LINE_CLKS, $time);
				error_count++;
				hs_gap = 0;
			end
			if (vs_gap > FRAME_CLKS) begin
				$display("No vsync falling edge in %0d clocks, at %0t ns", FRAME_CLKS, $time);
				error_count++;
				vs_gap = 0;
			end
			prev_hsync = video.hsync;
			prev_vsync = video.vsync;

			// Registered one clock later
			exp_hsync = (hp != 2);
			exp_vsync = (vp != 2);
			if (hp == 0 && vp == 0) look_up_expansion(color, exp_color);
			else exp_color = '0;

			// Line counter only moves on the last back porch clock
			line_done = (hp == 3) && (hc == H_LEN[3] - 1);
			if (hc == H_LEN[hp] - 1) begin
				hp = (hp + 1) % 4;
				hc = 0;
			end else hc++;
			if (line_done) begin
				if (vc == V_LEN[vp] - 1) begin
					vp = (vp + 1) % 4;
					vc = 0;
				end else vc++;
			end
		end
	end

endmodule

// File: testbench/vga_raster_tb.sv
`timescale 1ns/100ps

module vga_raster_tb;
	import vga_pkg::*;

	// Small raster, 15 clocks by 7 lines
	localparam int H_ACTIVE   = 8;
	localparam int H_FRONT    = 2;
	localparam int H_PULSE    = 3;
	localparam int H_BACK     = 2;
	localparam int V_ACTIVE   = 4;
	localparam int V_FRONT    = 1;
	localparam int V_PULSE    = 1;
	localparam int V_BACK     = 1;
	localparam int FRAME_CLKS = (H_ACTIVE + H_FRONT + H_PULSE + H_BACK) * 7;
	localparam int WAIT_LIMIT = 2 * FRAME_CLKS;
	localparam int MAX_TESTS  = 64;
	localparam string TESTS_FILE = "testbench/vga_raster_tests.txt";

	logic          M10k_pll;
	logic          reset;
	packed_color_t color = '0;
	coord_t        next_x, next_y;
	vga_out_t      video;

	// Rows of the tests file
	packed_color_t color_tab [MAX_TESTS];
	rgb_t          expect_tab [MAX_TESTS];
	int            num_tests;
	int            checker_errors;
	int            tb_errors;
	int            timeouts;

	vga_raster_top #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_PULSE(H_PULSE), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_PULSE(V_PULSE), .V_BACK(V_BACK)
	) vga_raster_top_inst (
		.M10k_pll(M10k_pll), .reset(reset), .color(color),
		.next_x(next_x), .next_y(next_y), .video(video)
	);

	vga_raster_checker #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_PULSE(H_PULSE), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_PULSE(V_PULSE), .V_BACK(V_BACK),
		.MAX_TESTS(MAX_TESTS)
	) vga_raster_checker_inst (
		.M10k_pll(M10k_pll), .reset(reset), .color(color), .next_x(next_x),
		.next_y(next_y), .video(video), .color_tab(color_tab), .expect_tab(expect_tab),
		.num_tests(num_tests), .error_count(checker_errors)
	);

	// 4 ns clock
	initial begin
		M10k_pll = 1'b0;
		forever #2 M10k_pll = ~M10k_pll;
	end

	// Renderer model, table entry picked by pixel index
	always @(posedge M10k_pll) begin
		if (num_tests > 0)
			color <= color_tab[(int'(next_x) + int'(next_y) * H_ACTIVE) % num_tests];
	end

	//////////////////////////////
	// Tests file and waits
	//////////////////////////////

	// Lines starting with # are column notes
	task automatic read_tests;
		int          fd;
		string       line;
		logic [9:0]  c;
		logic [23:0] e;
		fd = $fopen(TESTS_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open the tests file %s", TESTS_FILE);
			tb_errors++;
		end else begin
			while (!$feof(fd) && num_tests < MAX_TESTS) begin
				if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#") begin
					if ($sscanf(line, "%h %h", c, e) == 2) begin
						color_tab[num_tests] = c;
						expect_tab[num_tests] = e;
						num_tests++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Low level first, then back high
	task automatic wait_vsync_pulse;
		int cycles;
		cycles = 0;
		while (video.vsync !== 1'b0 && cycles < WAIT_LIMIT) begin
			@(posedge M10k_pll);
			cycles++;
		end
		while (video.vsync !== 1'b1 && cycles < WAIT_LIMIT) begin
			@(posedge M10k_pll);
			cycles++;
		end
		if (cycles >= WAIT_LIMIT) begin
			$display("Timed out after %0d clocks waiting for a vsync pulse", cycles);
			timeouts++;
		end
	endtask

	initial begin
		int frame;
		reset = 1'b1;
		num_tests = 0;
		tb_errors = 0;
		timeouts = 0;
		read_tests();
		if (num_tests == 0) begin
			$display("No colour entries found in %s", TESTS_FILE);
			tb_errors++;
		end
		repeat (5) @(posedge M10k_pll);
		reset <= 1'b0;
		// Three frames, each closed by its vsync pulse
		for (frame = 0; frame < 3 && timeouts == 0; frame++) wait_vsync_pulse();
		@(negedge M10k_pll);
		$display("Errors: checker %0d, testbench %0d, timeouts %0d",
			checker_errors, tb_errors, timeouts);
		if (checker_errors == 0 && tb_errors == 0 && timeouts == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: testbench/vga_raster_tests.txt
# Column 1: packed colour in hex, r[9:7] g[6:3] b[2:0]
# Column 2: expected 24-bit expansion in hex, red green blue
000 000000
3FF E0F0E0
380 E00000
078 00F000
007 0000E0
155 40A0A0
2AA A05040
081 200020
0C8 209000
1F3 60E060
30C C01080
246 8080C0

// File: sources.f
+incdir+include
logic/vga_pkg.sv
logic/line_timing.sv
logic/frame_timing.sv
logic/video_output.sv
logic/vga_raster_top.sv
testbench/vga_raster_checker.sv
testbench/vga_raster_tb.sv

// File: Makefile
# Verilator build and run of the VGA raster testbench

VERILATOR ?= verilator
TOP       ?= vga_raster_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
